//--- source/motoroPwm_defs.svh
`ifndef MOTORO_PWM_DEFS_SVH
`define MOTORO_PWM_DEFS_SVH

// width of pulse position sums and high-time counts
`define POS_W 16

// width of the PWM period counter
`define PWM_LEN_W 12

// width of the step length and the in-step cycle counter
`define STEP_LEN_W 16

// narrowest pulse the MOSFET driver can follow, in clk cycles
`define PWM_MIN_WIDTH 256

// steps in one full commutation cycle
`define STEPS_PER_CYCLE 12

`endif

//--- source/motoroPwmPkg.sv
package motoroPwmPkg;

    // why a reload did or did not start a pulse
    typedef enum logic [1:0] {
        skipNone     = 2'd0,
        skipMinLimit = 2'd1,
        skipNoActive = 2'd3
    } skipReason;

    // phase that conducts during the current step
    typedef enum logic [1:0] {
        phaseA    = 2'd0,
        phaseB    = 2'd1,
        phaseC    = 2'd2,
        phaseNone = 2'd3
    } phaseSel;

    // step number within the commutation cycle, 0 to 11
    typedef logic [3:0] stepNum;

endpackage

//--- source/stepTimingIf.sv
`timescale 1ns/1ps

interface stepTimingIf import motoroPwmPkg::*; ();

    // single-cycle strobes at the two ends of a step
    logic    first1;
    logic    first2;
    logic    last2;
    logic    last1;

    // decoded step state, valid while active is high
    stepNum  step;
    phaseSel phase;
    logic    active;

    modport seq (
        output first1,
        output first2,
        output last2,
        output last1,
        output step,
        output phase,
        output active
    );

    // generators and the loss tracker only listen
    modport user (
        input first1,
        input first2,
        input last2,
        input last1,
        input step,
        input phase,
        input active
    );

endinterface

//--- source/stepSequencer.sv
`timescale 1ns/1ps

`include "motoroPwm_defs.svh"

module stepSequencer import motoroPwmPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   pwmActive,
    input  logic [`STEP_LEN_W-1:0] stepLen,
    stepTimingIf.seq               timing
);

    logic                   activeQ;
    logic [`STEP_LEN_W-1:0] cycleCnt;
    logic [`STEP_LEN_W-1:0] lastIdx;
    logic [`STEP_LEN_W-1:0] last2Idx;
    stepNum                 stepQ;
    phaseSel                phaseDec;
    logic                   stepWrap;
    logic                   cycleWrap;

    assign lastIdx   = stepLen - `STEP_LEN_W'd1;
    assign last2Idx  = stepLen - `STEP_LEN_W'd2;
    assign cycleWrap = (cycleCnt == lastIdx);
    assign stepWrap  = (stepQ == stepNum'(`STEPS_PER_CYCLE - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            activeQ <= 1'b0;
        end else begin
            activeQ <= pwmActive;
        end
    end

    // counter and step stay at zero until the registered enable is up,
    // so step 0 opens on the first cycle that active is seen high
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cycleCnt <= '0;
            stepQ    <= '0;
        end else if (!(pwmActive && activeQ)) begin
            cycleCnt <= '0;
            stepQ    <= '0;
        end else if (cycleWrap) begin
            cycleCnt <= '0;
            stepQ    <= stepWrap ? stepNum'(0) : stepQ + stepNum'(1);
        end else begin
            cycleCnt <= cycleCnt + `STEP_LEN_W'd1;
        end
    end

    // four steps per phase, A then B then C
    always_comb begin
        if (!activeQ) begin
            phaseDec = phaseNone;
        end else begin
            case (stepQ)
                4'd0, 4'd1, 4'd2, 4'd3:   phaseDec = phaseA;
                4'd4, 4'd5, 4'd6, 4'd7:   phaseDec = phaseB;
                4'd8, 4'd9, 4'd10, 4'd11: phaseDec = phaseC;
                default:                  phaseDec = phaseNone;
            endcase
        end
    end

    assign timing.first1 = activeQ && (cycleCnt == `STEP_LEN_W'd0);
    assign timing.first2 = activeQ && (cycleCnt == `STEP_LEN_W'd1);
    assign timing.last2  = activeQ && (cycleCnt == last2Idx);
    assign timing.last1  = activeQ && cycleWrap;
    assign timing.step   = stepQ;
    assign timing.phase  = phaseDec;
    assign timing.active = activeQ;

    // shorter steps would make the four strobes overlap
    stepLenMin: assert property (@(posedge clk) disable iff (!rstN)
        activeQ |-> stepLen >= `STEP_LEN_W'd4)
        else $error("step length below 4 while active");

    stepRange: assert property (@(posedge clk) disable iff (!rstN)
        stepQ < stepNum'(`STEPS_PER_CYCLE))
        else $error("step number out of range");

endmodule

//--- source/phasePwmGen.sv
`timescale 1ns/1ps

`include "motoroPwm_defs.svh"

module phasePwmGen import motoroPwmPkg::*; #(
    parameter phaseSel myPhase = phaseA
) (
    input  logic                  clk,
    input  logic                  rstN,
    stepTimingIf.user             timing,
    input  logic [`PWM_LEN_W-1:0] pwmLenWant,
    input  logic [`POS_W-1:0]     pwmLenPos,
    output logic                  reload,
    output logic                  pwm
);

    logic [`PWM_LEN_W-1:0] periodCnt;
    logic [`POS_W-1:0]     remain;
    logic [`POS_W-1:0]     candSum;
    logic [`POS_W-1:0]     pulseCnt;
    logic                  isMine;
    logic                  cycleEnd;
    logic                  stepTail;
    logic                  pulseLoad;
    skipReason             skip;

    assign isMine = (timing.phase == myPhase);

    // remainder is carried across the whole cycle and dropped after step 11
    assign cycleEnd = timing.last1 && (timing.step == stepNum'(`STEPS_PER_CYCLE - 1));

    // no pulse may start in the last two cycles because the next step may
    // belong to another phase
    assign stepTail = timing.last2 || timing.last1;

    // the period counter restarts at every step start
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            periodCnt <= '0;
        end else if (!timing.active || timing.first1 || periodCnt == `PWM_LEN_W'd1) begin
            periodCnt <= pwmLenWant;
        end else begin
            periodCnt <= periodCnt - `PWM_LEN_W'd1;
        end
    end

    // only the conducting phase reports its reloads
    assign reload = isMine && (timing.first1 || periodCnt == `PWM_LEN_W'd1);

    // wanted width plus whatever earlier skipped periods left behind
    assign candSum = remain + pwmLenPos;

    always_comb begin
        if (!isMine) begin
            skip = skipNoActive;
        end else if (candSum < `POS_W'(`PWM_MIN_WIDTH)) begin
            skip = skipMinLimit;
        end else begin
            skip = skipNone;
        end
    end

    assign pulseLoad = reload && (skip == skipNone) && !stepTail;

    // a too-narrow pulse is not dropped but saved up until the
    // accumulated width is wide enough to drive
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            remain <= '0;
        end else if (!timing.active || cycleEnd) begin
            remain <= '0;
        end else if (reload) begin
            case (skip)
                skipMinLimit: remain <= candSum;
                skipNone:     remain <= '0;
                default:      remain <= remain;
            endcase
        end
    end

    // the pulse counter holds the high time left in the current pulse
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pulseCnt <= '0;
        end else if (!isMine || stepTail) begin
            pulseCnt <= '0;
        end else if (pulseLoad) begin
            pulseCnt <= candSum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - `POS_W'd1;
        end
    end

    // output drops at once when the drive is disabled mid-step
    assign pwm = (pulseCnt != '0) && timing.active;

    // phase changes only at step boundaries, and the tail clear must
    // already have emptied the counter by then
    pwmOnlyMine: assert property (@(posedge clk) disable iff (!rstN)
        !isMine |-> !pwm)
        else $error("pwm high while phase is not conducting");

    // every pulse starts from a reload that passed the minimum check
    pulseFullLoad: assert property (@(posedge clk) disable iff (!rstN)
        (pulseCnt != '0 && $past(pulseCnt) == '0) |->
            $past(reload) && $past(skip) == skipNone &&
            pulseCnt >= `POS_W'(`PWM_MIN_WIDTH))
        else $error("pulse started without a full-width reload");

endmodule

//--- source/lossTracker.sv
`timescale 1ns/1ps

`include "motoroPwm_defs.svh"

module lossTracker import motoroPwmPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    stepTimingIf.user         timing,
    input  logic [`POS_W-1:0] pwmLenPos,
    input  logic              reloadA,
    input  logic              reloadB,
    input  logic              reloadC,
    input  logic              pwmA,
    input  logic              pwmB,
    input  logic              pwmC,
    output logic [`POS_W-1:0] lostStep,
    output logic [`POS_W-1:0] lostSpan
);

    logic              selReload;
    logic              selPwm;
    logic [`POS_W-1:0] wantAcc;
    logic [`POS_W-1:0] realAcc;
    logic [`POS_W-1:0] wantNext;
    logic [`POS_W-1:0] realNext;
    logic [`POS_W-1:0] wantStepQ;
    logic [`POS_W-1:0] realStepQ;
    logic [`POS_W-1:0] wantSpan;
    logic [`POS_W-1:0] realSpan;
    logic              spanStart;

    // windows are half a commutation cycle, steps 0-5 and 6-11
    function automatic logic isWindowStart(input stepNum s);
        return (s == stepNum'(0)) || (s == stepNum'(6));
    endfunction

    // negative differences are folded by inversion, one short of the
    // true magnitude, so the top bit is always clear
    function automatic logic [`POS_W-1:0] lossMag(input logic [`POS_W-1:0] want,
                                                  input logic [`POS_W-1:0] got);
        logic [`POS_W-1:0] diff;
        diff = want - got;
        return diff[`POS_W-1] ? ~diff : diff;
    endfunction

    always_comb begin
        case (timing.phase)
            phaseA: begin
                selReload = reloadA;
                selPwm    = pwmA;
            end
            phaseB: begin
                selReload = reloadB;
                selPwm    = pwmB;
            end
            phaseC: begin
                selReload = reloadC;
                selPwm    = pwmC;
            end
            default: begin
                selReload = 1'b0;
                selPwm    = 1'b0;
            end
        endcase
    end

    assign wantNext  = wantAcc + (selReload ? pwmLenPos : '0);
    assign realNext  = realAcc + `POS_W'(selPwm);
    assign spanStart = isWindowStart(timing.step);

    // the step totals close on last2, so last1 counts toward the next step
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wantAcc   <= '0;
            realAcc   <= '0;
            wantStepQ <= '0;
            realStepQ <= '0;
            wantSpan  <= '0;
            realSpan  <= '0;
        end else if (!timing.active) begin
            wantAcc   <= '0;
            realAcc   <= '0;
            wantStepQ <= '0;
            realStepQ <= '0;
            wantSpan  <= '0;
            realSpan  <= '0;
        end else if (timing.last2) begin
            wantAcc   <= '0;
            realAcc   <= '0;
            wantStepQ <= wantNext;
            realStepQ <= realNext;
            wantSpan  <= (spanStart ? '0 : wantSpan) + wantNext;
            realSpan  <= (spanStart ? '0 : realSpan) + realNext;
        end else begin
            wantAcc   <= wantNext;
            realAcc   <= realNext;
        end
    end

    // on first2 of steps 0 and 6 the span sums still hold the window just closed
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lostStep <= '0;
            lostSpan <= '0;
        end else if (timing.first2) begin
            lostStep <= lossMag(wantStepQ, realStepQ);
            if (spanStart) begin
                lostSpan <= lossMag(wantSpan, realSpan);
            end
        end
    end

endmodule

//--- source/motoroPwmTop.sv
`timescale 1ns/1ps

`include "motoroPwm_defs.svh"

module motoroPwmTop import motoroPwmPkg::*; (
    input  logic                   clk,
    input  logic                   rstN,
    input  logic                   pwmActive,
    input  logic [`STEP_LEN_W-1:0] stepLen,
    input  logic [`PWM_LEN_W-1:0]  pwmLenWant,
    input  logic [`POS_W-1:0]      pwmLenPos,
    output logic                   pwmA,
    output logic                   pwmB,
    output logic                   pwmC,
    output stepNum                 step,
    output logic [`POS_W-1:0]      lostStep,
    output logic [`POS_W-1:0]      lostSpan
);

    logic reloadA;
    logic reloadB;
    logic reloadC;

    stepTimingIf timing ();

    stepSequencer seq_i (
        .clk       (clk),
        .rstN      (rstN),
        .pwmActive (pwmActive),
        .stepLen   (stepLen),
        .timing    (timing.seq)
    );

    // one generator per phase, only the conducting one produces pulses
    phasePwmGen #(.myPhase(phaseA)) genA_i (
        .clk        (clk),
        .rstN       (rstN),
        .timing     (timing.user),
        .pwmLenWant (pwmLenWant),
        .pwmLenPos  (pwmLenPos),
        .reload     (reloadA),
        .pwm        (pwmA)
    );

    phasePwmGen #(.myPhase(phaseB)) genB_i (
        .clk        (clk),
        .rstN       (rstN),
        .timing     (timing.user),
        .pwmLenWant (pwmLenWant),
        .pwmLenPos  (pwmLenPos),
        .reload     (reloadB),
        .pwm        (pwmB)
    );

    phasePwmGen #(.myPhase(phaseC)) genC_i (
        .clk        (clk),
        .rstN       (rstN),
        .timing     (timing.user),
        .pwmLenWant (pwmLenWant),
        .pwmLenPos  (pwmLenPos),
        .reload     (reloadC),
        .pwm        (pwmC)
    );

    lossTracker loss_i (
        .clk       (clk),
        .rstN      (rstN),
        .timing    (timing.user),
        .pwmLenPos (pwmLenPos),
        .reloadA   (reloadA),
        .reloadB   (reloadB),
        .reloadC   (reloadC),
        .pwmA      (pwmA),
        .pwmB      (pwmB),
        .pwmC      (pwmC),
        .lostStep  (lostStep),
        .lostSpan  (lostSpan)
    );

    assign step = timing.step;

endmodule

//--- sim/motoroPwmTb.sv
`timescale 1ns/1ps

`include "motoroPwm_defs.svh"

module motoroPwmTb import motoroPwmPkg::*; ();

    localparam int NUM_ROWS = 12;

    logic                   clk = 1'b0;
    logic                   rstN;
    logic                   pwmActive;
    logic [`STEP_LEN_W-1:0] stepLen;
    logic [`PWM_LEN_W-1:0]  pwmLenWant;
    logic [`POS_W-1:0]      pwmLenPos;
    logic                   pwmA;
    logic                   pwmB;
    logic                   pwmC;
    stepNum                 step;
    logic [`POS_W-1:0]      lostStep;
    logic [`POS_W-1:0]      lostSpan;

    // stimulus table, one entry per row
    logic                   rowActive  [NUM_ROWS];
    logic [`STEP_LEN_W-1:0] rowStepLen [NUM_ROWS];
    logic [`PWM_LEN_W-1:0]  rowWant    [NUM_ROWS];
    logic [`POS_W-1:0]      rowPos     [NUM_ROWS];
    int                     rowSteps   [NUM_ROWS];
    int                     rowCount;
    logic                   tableReady = 1'b0;
    logic [31:0]            lcgState;

    // reference model registers
    logic                   mActQ;
    logic [`STEP_LEN_W-1:0] mCnt;
    stepNum                 mStep;
    logic [`PWM_LEN_W-1:0]  mPeriod;
    logic [`POS_W-1:0]      mRem   [3];
    logic [`POS_W-1:0]      mPulse [3];
    logic [`POS_W-1:0]      mWantAcc;
    logic [`POS_W-1:0]      mRealAcc;
    logic [`POS_W-1:0]      mWantStep;
    logic [`POS_W-1:0]      mRealStep;
    logic [`POS_W-1:0]      mWantSpan;
    logic [`POS_W-1:0]      mRealSpan;
    logic [`POS_W-1:0]      mLostStep;
    logic [`POS_W-1:0]      mLostSpan;

    motoroPwmTop dut_i (
        .clk        (clk),
        .rstN       (rstN),
        .pwmActive  (pwmActive),
        .stepLen    (stepLen),
        .pwmLenWant (pwmLenWant),
        .pwmLenPos  (pwmLenPos),
        .pwmA       (pwmA),
        .pwmB       (pwmB),
        .pwmC       (pwmC),
        .step       (step),
        .lostStep   (lostStep),
        .lostSpan   (lostSpan)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] nextRand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // a negative shortfall is reported as its bitwise inverse
    function automatic logic [`POS_W-1:0] lossOf(input logic [`POS_W-1:0] want,
                                                 input logic [`POS_W-1:0] got);
        logic [`POS_W-1:0] diff;
        diff = want - got;
        return diff[`POS_W-1] ? ~diff : diff;
    endfunction

    task automatic stopOnError();
        $display("TB FAILED");
        $fatal(1, "first mismatch ends the run");
    endtask

    task automatic checkPwm(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            stopOnError();
        end
    endtask

    task automatic checkStep(input stepNum got, input stepNum exp);
        if (got !== exp) begin
            $display("** Error: step = 0x%h, expected 0x%h at %0t", got, exp, $time);
            stopOnError();
        end
    endtask

    task automatic checkLoss(input string name, input logic [`POS_W-1:0] got,
                             input logic [`POS_W-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
            stopOnError();
        end
    endtask

    task automatic compareOutputs();
        checkPwm("pwmA", pwmA, mActQ && (mPulse[0] != '0));
        checkPwm("pwmB", pwmB, mActQ && (mPulse[1] != '0));
        checkPwm("pwmC", pwmC, mActQ && (mPulse[2] != '0));
        checkStep(step, mStep);
        checkLoss("lostStep", lostStep, mLostStep);
        checkLoss("lostSpan", lostSpan, mLostSpan);
    endtask

    task automatic addRow(input logic act, input logic [`STEP_LEN_W-1:0] len,
                          input logic [`PWM_LEN_W-1:0] want,
                          input logic [`POS_W-1:0] pos, input int steps);
        rowActive[rowCount]  = act;
        rowStepLen[rowCount] = len;
        rowWant[rowCount]    = want;
        rowPos[rowCount]     = pos;
        rowSteps[rowCount]   = steps;
        rowCount++;
    endtask

    // stepLen only changes across an idle row, so no step sees two lengths
    task automatic buildTable();
        logic [`POS_W-1:0] pos;
        rowCount = 0;
        lcgState = 32'hb9af_790c;
        addRow(1'b0, `STEP_LEN_W'd40, `PWM_LEN_W'd100, `POS_W'd300, 2);
        // wide pulses, three periods per step
        addRow(1'b1, `STEP_LEN_W'd1200, `PWM_LEN_W'd400, `POS_W'd300, 12);
        // narrow pulses are saved up until the sum reaches the minimum
        addRow(1'b1, `STEP_LEN_W'd1200, `PWM_LEN_W'd400, `POS_W'd100, 12);
        addRow(1'b1, `STEP_LEN_W'd1200, `PWM_LEN_W'd500, `POS_W'd600, 6);
        addRow(1'b0, `STEP_LEN_W'd600, `PWM_LEN_W'd300, `POS_W'd200, 1);
        for (int i = 0; i < 6; i++) begin
            lcgState = nextRand(lcgState);
            pos      = `POS_W'(32'd40 + (lcgState >> 22));
            addRow(1'b1, `STEP_LEN_W'd600, `PWM_LEN_W'd300, pos, 6);
        end
        addRow(1'b0, `STEP_LEN_W'd600, `PWM_LEN_W'd300, `POS_W'd0, 2);
        tableReady = 1'b1;
    endtask

    task automatic clearModel();
        mActQ     = 1'b0;
        mCnt      = '0;
        mStep     = '0;
        mPeriod   = '0;
        mWantAcc  = '0;
        mRealAcc  = '0;
        mWantStep = '0;
        mRealStep = '0;
        mWantSpan = '0;
        mRealSpan = '0;
        mLostStep = '0;
        mLostSpan = '0;
        for (int p = 0; p < 3; p++) begin
            mRem[p]   = '0;
            mPulse[p] = '0;
        end
    endtask

    // one clock of the model, using the inputs held before this edge
    task automatic advanceModel();
        logic [`STEP_LEN_W-1:0] lenM1;
        logic                   f1;
        logic                   f2;
        logic                   l2;
        logic                   l1;
        logic                   rel;
        logic                   spanStart;
        logic                   selPwm;
        logic [1:0]             cond;
        logic [`POS_W-1:0]      cand;
        logic [`POS_W-1:0]      wantN;
        logic [`POS_W-1:0]      realN;
        logic [`POS_W-1:0]      nextRem   [3];
        logic [`POS_W-1:0]      nextPulse [3];

        lenM1     = stepLen - `STEP_LEN_W'd1;
        f1        = mActQ && (mCnt == '0);
        f2        = mActQ && (mCnt == `STEP_LEN_W'd1);
        l2        = mActQ && (mCnt == stepLen - `STEP_LEN_W'd2);
        l1        = mActQ && (mCnt == lenM1);
        rel       = mActQ && (f1 || mPeriod == `PWM_LEN_W'd1);
        // steps 0-3 drive A, 4-7 drive B, 8-11 drive C
        cond      = mActQ ? 2'(mStep / stepNum'(4)) : 2'd3;
        spanStart = (mStep == stepNum'(0)) || (mStep == stepNum'(6));
        selPwm    = (cond != 2'd3) && mActQ && (mPulse[cond] != '0);
        wantN     = mWantAcc + ((rel && cond != 2'd3) ? pwmLenPos : '0);
        realN     = mRealAcc + `POS_W'(selPwm);

        for (int p = 0; p < 3; p++) begin
            cand         = mRem[p] + pwmLenPos;
            nextRem[p]   = mRem[p];
            nextPulse[p] = '0;
            if (!mActQ || (l1 && mStep == stepNum'(`STEPS_PER_CYCLE - 1))) begin
                nextRem[p] = '0;
            end else if (rel && cond == 2'(p)) begin
                nextRem[p] = (cand < `POS_W'(`PWM_MIN_WIDTH)) ? cand : '0;
            end
            // no pulse survives into or starts in the last two cycles
            if (cond == 2'(p) && !l2 && !l1) begin
                if (rel && cand >= `POS_W'(`PWM_MIN_WIDTH)) begin
                    nextPulse[p] = cand;
                end else if (mPulse[p] != '0) begin
                    nextPulse[p] = mPulse[p] - `POS_W'd1;
                end
            end
        end

        if (f2) begin
            mLostStep = lossOf(mWantStep, mRealStep);
            if (spanStart) begin
                mLostSpan = lossOf(mWantSpan, mRealSpan);
            end
        end
        if (!mActQ) begin
            mWantAcc  = '0;
            mRealAcc  = '0;
            mWantStep = '0;
            mRealStep = '0;
            mWantSpan = '0;
            mRealSpan = '0;
        end else if (l2) begin
            mWantSpan = (spanStart ? '0 : mWantSpan) + wantN;
            mRealSpan = (spanStart ? '0 : mRealSpan) + realN;
            mWantStep = wantN;
            mRealStep = realN;
            mWantAcc  = '0;
            mRealAcc  = '0;
        end else begin
            mWantAcc  = wantN;
            mRealAcc  = realN;
        end

        for (int p = 0; p < 3; p++) begin
            mRem[p]   = nextRem[p];
            mPulse[p] = nextPulse[p];
        end
        mPeriod = (!mActQ || rel) ? pwmLenWant : mPeriod - `PWM_LEN_W'd1;

        if (!(pwmActive && mActQ)) begin
            mCnt  = '0;
            mStep = '0;
        end else if (mCnt == lenM1) begin
            mCnt  = '0;
            mStep = (mStep == stepNum'(`STEPS_PER_CYCLE - 1)) ? stepNum'(0)
                                                              : mStep + stepNum'(1);
        end else begin
            mCnt = mCnt + `STEP_LEN_W'd1;
        end
        mActQ = pwmActive;
    endtask

    initial begin
        rstN       = 1'b0;
        pwmActive  = 1'b0;
        stepLen    = `STEP_LEN_W'd40;
        pwmLenWant = `PWM_LEN_W'd100;
        pwmLenPos  = `POS_W'd0;
        clearModel();
        buildTable();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        compareOutputs();
        for (int r = 0; r < rowCount; r++) begin
            for (int c = 0; c < rowSteps[r] * int'(rowStepLen[r]); c++) begin
                @(posedge clk);
                advanceModel();
                if (c == 0) begin
                    pwmActive  <= rowActive[r];
                    stepLen    <= rowStepLen[r];
                    pwmLenWant <= rowWant[r];
                    pwmLenPos  <= rowPos[r];
                end
                @(negedge clk);
                compareOutputs();
            end
        end
        $display("TB PASSED");
        $finish;
    end

    // budget is the table length plus reset and some slack
    initial begin
        int budget;
        wait (tableReady === 1'b1);
        budget = 16 + 1000;
        for (int r = 0; r < rowCount; r++) begin
            budget += rowSteps[r] * int'(rowStepLen[r]);
        end
        repeat (budget) @(posedge clk);
        $display("timeout: the table was not finished after %0d clock cycles", budget);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- motoroPwm.f
+incdir+source
source/motoroPwmPkg.sv
source/stepTimingIf.sv
source/stepSequencer.sv
source/phasePwmGen.sv
source/lossTracker.sv
source/motoroPwmTop.sv
sim/motoroPwmTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = motoroPwmTb
FILELIST  = motoroPwm.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
